// ==== Bender.yml ====
package:
  name: hm_host_mem

sources:
  - common/hm_pkg.sv
  - buffer/hm_buffer_bank.sv
  - buffer/hm_buffer_window.sv
  - sequencer/hm_sequencer.sv
  - logic/hm_csr_regs.sv
  - logic/hm_top.sv
  - target: simulation
    files:
      - bench/hm_tb.sv

// ==== bench/hm_tb.sv ====
module hm_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import hm_pkg::*;

  localparam logic [31:0] TIMEOUT_CYCLES = 32'd64;
  localparam logic [3:0]  CSR_BLOCK      = 4'h2;
  localparam int          STAT_POLLS     = 200;

  logic          sys_clk;
  logic          sys_rst;
  logic [13:0]   csr_a_i;
  logic          csr_we_i;
  hm_word_t      csr_di_i;
  hm_word_t      csr_do_o;
  logic [31:0]   wb_adr_i;
  hm_word_t      wb_dat_i;
  byte_en_t      wb_sel_i;
  logic          wb_cyc_i;
  logic          wb_stb_i;
  logic          wb_we_i;
  hm_word_t      wb_dat_o;
  logic          wb_ack_o;
  hm_qword_t     hm_addr_i;
  hm_qword_t     hm_data_o;
  logic          tx_start_o;
  logic          wr_start_o;
  logic          tx_end_i;
  logic          rx_done_i;
  logic          wr_end_i;
  hm_qword_t     engine_addr_o;
  hm_word_t      engine_data_o;
  logic          snoop_o;
  requester_id_t requester_id_o;
  logic [7:0]    cfg_bus_number_i;
  logic [4:0]    cfg_device_number_i;
  logic [2:0]    cfg_function_number_i;
  logic          irq_o;

  integer    seed;
  int        check_errors;
  int        timeouts;
  hm_qword_t mem_model [0:511];
  hm_qword_t addr_model;
  hm_word_t  data_model;
  logic      snoop_model;
  logic      override_model;

  hm_top #(
    .timeout_cycles(TIMEOUT_CYCLES),
    .csr_block     (CSR_BLOCK)
  ) uut (
    .sys_clk(sys_clk), .sys_rst(sys_rst),
    .csr_a_i(csr_a_i), .csr_we_i(csr_we_i), .csr_di_i(csr_di_i), .csr_do_o(csr_do_o),
    .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i), .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .hm_addr_i(hm_addr_i), .hm_data_o(hm_data_o),
    .tx_start_o(tx_start_o), .wr_start_o(wr_start_o), .tx_end_i(tx_end_i),
    .rx_done_i(rx_done_i), .wr_end_i(wr_end_i), .engine_addr_o(engine_addr_o),
    .engine_data_o(engine_data_o), .snoop_o(snoop_o), .requester_id_o(requester_id_o),
    .cfg_bus_number_i(cfg_bus_number_i), .cfg_device_number_i(cfg_device_number_i),
    .cfg_function_number_i(cfg_function_number_i), .irq_o(irq_o)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      check_errors++;
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
               $time, name, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out at %0d ns while waiting for %s", $time, what);
  endtask

  // Wishbone byte b lands in stored lane 3-b
  task automatic model_write(input logic [31:0] adr, input hm_word_t dat,
                             input byte_en_t sel);
    hm_word_t stored;
    stored = adr[2] ? mem_model[adr[11:3]][63:32] : mem_model[adr[11:3]][31:0];
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        stored[8*(3-b) +: 8] = dat[8*b +: 8];
      end
    end
    if (adr[2]) begin
      mem_model[adr[11:3]][63:32] = stored;
    end else begin
      mem_model[adr[11:3]][31:0] = stored;
    end
  endtask

  function automatic hm_word_t model_read(input logic [31:0] adr);
    hm_word_t stored;
    hm_word_t result;
    stored = adr[2] ? mem_model[adr[11:3]][63:32] : mem_model[adr[11:3]][31:0];
    for (int b = 0; b < 4; b++) begin
      result[8*b +: 8] = stored[8*(3-b) +: 8];
    end
    return result;
  endfunction

  function automatic logic [13:0] csr_addr(input csr_offset_t offset);
    return {CSR_BLOCK, offset};
  endfunction

  function automatic hm_word_t ctrl_value(input logic irq_en, input logic rd,
                                          input logic wr);
    hm_word_t w;
    w = '0;
    w[0] = irq_en;
    w[1] = rd;
    w[2] = wr;
    w[4] = snoop_model;
    w[5] = override_model;
    return w;
  endfunction

  task automatic wb_access(input logic we, input logic [31:0] adr, input hm_word_t dat,
                           input byte_en_t sel, output hm_word_t rdata);
    int cycles;
    cycles = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    do begin
      @(negedge sys_clk);
      cycles++;
    end while (wb_ack_o !== 1'b1 && cycles < 8);
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (wb_ack_o !== 1'b1) begin
      report_timeout("wb_ack_o");
    end else begin
      // Ack follows the request by one cycle
      check_value("wb_ack_o latency", cycles, 1);
      @(negedge sys_clk);
      check_value("wb_ack_o", wb_ack_o, 1'b0);
    end
  endtask

  task automatic csr_write(input logic [13:0] a, input hm_word_t data);
    csr_a_i  = a;
    csr_di_i = data;
    csr_we_i = 1'b1;
    @(negedge sys_clk);
    csr_we_i = 1'b0;
  endtask

  task automatic csr_read(input logic [13:0] a, output hm_word_t rdata);
    csr_a_i  = a;
    csr_we_i = 1'b0;
    @(negedge sys_clk);
    rdata = csr_do_o;
  endtask

  task automatic wait_start(input logic for_write);
    int cycles;
    cycles = 0;
    while ((for_write ? wr_start_o : tx_start_o) !== 1'b1 && cycles < 16) begin
      @(negedge sys_clk);
      cycles++;
    end
    if ((for_write ? wr_start_o : tx_start_o) !== 1'b1) begin
      report_timeout(for_write ? "wr_start_o" : "tx_start_o");
    end
  endtask

  task automatic wait_stat(input hm_word_t mask, output hm_word_t stat);
    int polls;
    polls = 0;
    stat  = '0;
    while ((stat & mask) == 0 && polls < STAT_POLLS) begin
      csr_read(csr_addr(CSR_STAT), stat);
      polls++;
    end
    if ((stat & mask) == 0) begin
      report_timeout("a STAT event");
    end
  endtask

  // 0 is tx_end, 1 is rx_done, 2 is wr_end
  task automatic pulse_engine(input int which);
    tx_end_i  = which == 0;
    rx_done_i = which == 1;
    wr_end_i  = which == 2;
    @(negedge sys_clk);
    tx_end_i  = 1'b0;
    rx_done_i = 1'b0;
    wr_end_i  = 1'b0;
  endtask

  task automatic clear_stat_idle();
    hm_word_t rdata;
    csr_read(csr_addr(CSR_STATE), rdata);
    check_value("CSR_STATE", rdata, 32'd0);
    csr_write(csr_addr(CSR_STAT), 32'h27);
    check_value("irq_o", irq_o, 1'b0);
    csr_read(csr_addr(CSR_STAT), rdata);
    check_value("CSR_STAT", rdata, 32'd0);
  endtask

  task automatic buffer_readback();
    logic [31:0] adr;
    hm_word_t    dat;
    hm_word_t    rdata;
    byte_en_t    sel;
    int          kind;
    // Fill every word of both banks first
    for (int i = 0; i < 1024; i++) begin
      adr       = $random(seed);
      adr[13:2] = {2'b00, i[9:0]};
      dat       = $random(seed);
      wb_access(1'b1, adr, dat, 4'hf, rdata);
      model_write(adr, dat, 4'hf);
      if (timeouts != 0) return;
    end
    for (int i = 0; i < 400; i++) begin
      adr  = $random(seed);
      dat  = $random(seed);
      sel  = $random(seed);
      kind = {$random(seed)} % 3;
      if (kind == 2) begin
        if (adr[13:12] == 2'b00) begin
          adr[13] = 1'b1;
        end
        wb_access(adr[0], adr, dat, sel, rdata);
        check_value("wb_dat_o", rdata, 32'd0);
      end else begin
        adr[13:12] = 2'b00;
        if (kind == 0) begin
          wb_access(1'b1, adr, dat, sel, rdata);
          model_write(adr, dat, sel);
        end else begin
          wb_access(1'b0, adr, dat, sel, rdata);
          check_value("wb_dat_o", rdata, model_read(adr));
        end
      end
      if (timeouts != 0) return;
    end
  endtask

  task automatic host_port_reads();
    hm_qword_t addr;
    for (int i = 0; i < 200; i++) begin
      addr      = {$random(seed), $random(seed)};
      hm_addr_i = addr;
      @(negedge sys_clk);
      check_value("hm_data_o", hm_data_o, mem_model[addr[11:3]]);
    end
  endtask

  task automatic csr_register_access();
    hm_word_t lo;
    hm_word_t hi;
    hm_word_t id_word;
    hm_word_t rdata;
    cfg_bus_number_i      = $random(seed);
    cfg_device_number_i   = $random(seed);
    cfg_function_number_i = $random(seed);
    lo         = $random(seed);
    hi         = $random(seed);
    id_word    = $random(seed);
    data_model = $random(seed);
    csr_write(csr_addr(CSR_ADDR_LOW), lo);
    csr_write(csr_addr(CSR_ADDR_HIGH), hi);
    csr_write(csr_addr(CSR_DATA), data_model);
    csr_write(csr_addr(CSR_ID), id_word);
    csr_read(csr_addr(CSR_ADDR_LOW), rdata);
    check_value("CSR_ADDR_LOW", rdata, lo);
    csr_read(csr_addr(CSR_ADDR_HIGH), rdata);
    check_value("CSR_ADDR_HIGH", rdata, hi);
    csr_read(csr_addr(CSR_DATA), rdata);
    check_value("CSR_DATA", rdata, data_model);
    csr_read(csr_addr(CSR_ID), rdata);
    check_value("CSR_ID", rdata, {16'h0, id_word[15:0]});
    // Another block neither answers nor takes writes
    csr_write({CSR_BLOCK ^ 4'h5, CSR_ADDR_LOW}, ~lo);
    csr_read({CSR_BLOCK ^ 4'h5, CSR_ADDR_LOW}, rdata);
    check_value("csr_do_o", rdata, 32'd0);
    csr_read(csr_addr(CSR_ADDR_LOW), rdata);
    check_value("CSR_ADDR_LOW", rdata, lo);
    snoop_model    = $random(seed);
    override_model = 1'b1;
    csr_write(csr_addr(CSR_CTRL), ctrl_value(1'b0, 1'b0, 1'b0));
    check_value("requester_id_o", requester_id_o, id_word[15:0]);
    check_value("snoop_o", snoop_o, snoop_model);
    override_model = 1'b0;
    csr_write(csr_addr(CSR_CTRL), ctrl_value(1'b0, 1'b0, 1'b0));
    check_value("requester_id_o", requester_id_o,
                {cfg_bus_number_i, cfg_device_number_i, cfg_function_number_i});
    csr_read(csr_addr(CSR_STAT), rdata);
    check_value("CSR_STAT", rdata, 32'd0);
  endtask

  task automatic read_transfer();
    hm_word_t stat;
    addr_model = {$random(seed), $random(seed)};
    csr_write(csr_addr(CSR_ADDR_LOW), addr_model[31:0]);
    csr_write(csr_addr(CSR_ADDR_HIGH), addr_model[63:32]);
    csr_write(csr_addr(CSR_CTRL), ctrl_value(1'b1, 1'b1, 1'b0));
    wait_start(1'b0);
    if (timeouts != 0) return;
    check_value("engine_addr_o", engine_addr_o, addr_model & ~64'hfff);
    pulse_engine(0);
    pulse_engine(1);
    wait_stat(32'h1, stat);
    if (timeouts != 0) return;
    check_value("CSR_STAT", stat, 32'h1);
    check_value("irq_o", irq_o, 1'b1);
    clear_stat_idle();
  endtask

  task automatic write_transfer();
    hm_word_t stat;
    hm_word_t rdata;
    data_model = $random(seed);
    addr_model = {$random(seed), $random(seed)};
    csr_write(csr_addr(CSR_DATA), data_model);
    csr_write(csr_addr(CSR_ADDR_LOW), addr_model[31:0]);
    csr_write(csr_addr(CSR_ADDR_HIGH), addr_model[63:32]);
    csr_write(csr_addr(CSR_CTRL), ctrl_value(1'b1, 1'b0, 1'b1));
    wait_start(1'b1);
    if (timeouts != 0) return;
    check_value("engine_addr_o", engine_addr_o, addr_model);
    check_value("engine_data_o", engine_data_o, data_model);
    // A read start while busy must be dropped
    csr_write(csr_addr(CSR_CTRL), ctrl_value(1'b1, 1'b1, 1'b0));
    for (int i = 0; i < 6; i++) begin
      @(negedge sys_clk);
      check_value("tx_start_o", tx_start_o, 1'b0);
    end
    csr_read(csr_addr(CSR_STATE), rdata);
    check_value("CSR_STATE", rdata, 32'd3);
    pulse_engine(2);
    wait_stat(32'h1, stat);
    if (timeouts != 0) return;
    check_value("CSR_STAT", stat, 32'h1);
    clear_stat_idle();
  endtask

  task automatic transfer_timeouts();
    hm_word_t stat;
    hm_word_t mask;
    hm_word_t expected;
    for (int k = 0; k < 3; k++) begin
      csr_write(csr_addr(CSR_CTRL), ctrl_value(1'b1, k != 2, k == 2));
      wait_start(k == 2);
      if (timeouts != 0) return;
      if (k == 1) begin
        pulse_engine(0);
      end
      case (k)
        0:       mask = 32'h02;
        1:       mask = 32'h04;
        default: mask = 32'h20;
      endcase
      // Write timeout also raises END
      expected = (k == 2) ? 32'h21 : mask;
      wait_stat(mask, stat);
      if (timeouts != 0) return;
      check_value("CSR_STAT", stat, expected);
      check_value("irq_o", irq_o, 1'b1);
      clear_stat_idle();
    end
  endtask

  initial begin
    seed                  = 32'h991d;
    check_errors          = 0;
    timeouts              = 0;
    snoop_model           = 1'b1;
    override_model        = 1'b0;
    sys_rst               = 1'b1;
    csr_a_i               = '0;
    csr_we_i              = 1'b0;
    csr_di_i              = '0;
    wb_adr_i              = '0;
    wb_dat_i              = '0;
    wb_sel_i              = '0;
    wb_cyc_i              = 1'b0;
    wb_stb_i              = 1'b0;
    wb_we_i               = 1'b0;
    hm_addr_i             = '0;
    tx_end_i              = 1'b0;
    rx_done_i             = 1'b0;
    wr_end_i              = 1'b0;
    cfg_bus_number_i      = '0;
    cfg_device_number_i   = '0;
    cfg_function_number_i = '0;
    repeat (2) @(negedge sys_clk);
    sys_rst = 1'b0;
    check_value("csr_do_o", csr_do_o, 32'd0);
    check_value("wb_ack_o", wb_ack_o, 1'b0);
    check_value("tx_start_o", tx_start_o, 1'b0);
    check_value("wr_start_o", wr_start_o, 1'b0);
    check_value("irq_o", irq_o, 1'b0);
    check_value("snoop_o", snoop_o, 1'b1);
    buffer_readback();
    if (timeouts == 0) host_port_reads();
    if (timeouts == 0) csr_register_access();
    if (timeouts == 0) read_transfer();
    if (timeouts == 0) write_transfer();
    if (timeouts == 0) transfer_timeouts();
    $display("Errors: %0d check failures, %0d timeouts", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== buffer/hm_buffer_bank.sv ====
module hm_buffer_bank (
  input  logic               sys_clk,
  input  hm_pkg::buf_index_t index_i,
  input  hm_pkg::hm_word_t   wdata_i,
  input  hm_pkg::byte_en_t   we_i,
  output hm_pkg::hm_word_t   rdata_o
);

  import hm_pkg::*;

  localparam int DEPTH = 2 ** $bits(buf_index_t);
  localparam int LANES = $bits(byte_en_t);

  hm_word_t mem [DEPTH];
  hm_word_t merged;

  // Old word with the enabled lanes replaced
  always_comb begin
    merged = mem[index_i];
    for (int i = 0; i < LANES; i++) begin
      if (we_i[i]) begin
        merged[8*i +: 8] = wdata_i[8*i +: 8];
      end
    end
  end

  // Write first so the read port sees the new data
  always_ff @(posedge sys_clk) begin
    if (|we_i) begin
      mem[index_i] <= merged;
    end
    rdata_o <= merged;
  end

endmodule

// ==== buffer/hm_buffer_window.sv ====
module hm_buffer_window (
  input  logic               sys_clk,
  input  logic               sys_rst,

  input  logic [31:0]        wb_adr_i,
  input  hm_pkg::hm_word_t   wb_dat_i,
  input  hm_pkg::byte_en_t   wb_sel_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  output hm_pkg::hm_word_t   wb_dat_o,
  output logic               wb_ack_o,

  input  hm_pkg::hm_qword_t  hm_addr_i,
  output hm_pkg::hm_qword_t  hm_data_o,

  input  hm_pkg::hm_word_t   bank_rd_lo_i,
  input  hm_pkg::hm_word_t   bank_rd_hi_i,
  output hm_pkg::buf_index_t bank_index_o,
  output hm_pkg::hm_word_t   bank_wdata_o,
  output hm_pkg::byte_en_t   bank_we_lo_o,
  output hm_pkg::byte_en_t   bank_we_hi_o
);

  import hm_pkg::*;

  logic     wb_en;
  logic     in_buf;
  logic     buf_write;
  byte_en_t sel_swapped;
  logic     in_buf_q;
  logic     bank_hi_q;
  hm_word_t rd_word;

  // Host side is big endian and Wishbone little endian
  function automatic hm_word_t swap_bytes(hm_word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  assign wb_en     = wb_cyc_i & wb_stb_i;
  assign in_buf    = ~wb_adr_i[13] & ~wb_adr_i[12];
  assign buf_write = wb_en & wb_we_i & in_buf;

  assign sel_swapped = {wb_sel_i[0], wb_sel_i[1], wb_sel_i[2], wb_sel_i[3]};

  // Wishbone takes the port when it is active
  assign bank_index_o = wb_en ? wb_adr_i[11:3] : hm_addr_i[11:3];
  assign bank_wdata_o = swap_bytes(wb_dat_i);

  assign bank_we_lo_o = (buf_write & ~wb_adr_i[2]) ? sel_swapped : '0;
  assign bank_we_hi_o = (buf_write &  wb_adr_i[2]) ? sel_swapped : '0;

  assign hm_data_o = {bank_rd_hi_i, bank_rd_lo_i};

  // Region and bank of the access, kept for the ack cycle
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      in_buf_q  <= 1'b0;
      bank_hi_q <= 1'b0;
    end else if (wb_en) begin
      in_buf_q  <= in_buf;
      bank_hi_q <= wb_adr_i[2];
    end
  end

  assign rd_word  = bank_hi_q ? bank_rd_hi_i : bank_rd_lo_i;
  assign wb_dat_o = in_buf_q ? swap_bytes(rd_word) : '0;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_en & ~wb_ack_o;
    end
  end

endmodule

// ==== common/hm_pkg.sv ====
package hm_pkg;

  typedef logic [31:0] hm_word_t;
  typedef logic [63:0] hm_qword_t;
  typedef logic [8:0]  buf_index_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [9:0]  csr_offset_t;

  // Bus, device and function numbers
  typedef logic [15:0] requester_id_t;

  typedef enum logic [1:0] {
    HM_IDLE  = 2'd0,
    HM_SEND  = 2'd1,
    HM_RECV  = 2'd2,
    HM_WRITE = 2'd3
  } hm_state_e;

  // CSR offsets within the block
  localparam csr_offset_t CSR_STAT      = 10'd0;
  localparam csr_offset_t CSR_CTRL      = 10'd1;
  localparam csr_offset_t CSR_ADDR_LOW  = 10'd2;
  localparam csr_offset_t CSR_ADDR_HIGH = 10'd3;
  localparam csr_offset_t CSR_STATE     = 10'd8;
  localparam csr_offset_t CSR_DATA      = 10'd11;
  localparam csr_offset_t CSR_ID        = 10'd12;

  // STAT bits are write one to clear
  localparam int STAT_END        = 0;
  localparam int STAT_TX_TIMEOUT = 1;
  localparam int STAT_RX_TIMEOUT = 2;
  localparam int STAT_WR_TIMEOUT = 5;

  // CTRL bits
  localparam int CTRL_IRQ_EN      = 0;
  localparam int CTRL_START_READ  = 1;
  localparam int CTRL_START_WRITE = 2;
  localparam int CTRL_SNOOP       = 4;
  localparam int CTRL_OVERRIDE_ID = 5;

  // Read requests are aligned on a host page
  localparam int PAGE_BITS = 12;

endpackage

// ==== list.f ====
common/hm_pkg.sv
buffer/hm_buffer_bank.sv
buffer/hm_buffer_window.sv
sequencer/hm_sequencer.sv
logic/hm_csr_regs.sv
logic/hm_top.sv
bench/hm_tb.sv

// ==== logic/hm_csr_regs.sv ====
module hm_csr_regs #(
  parameter logic [3:0] csr_block = 4'h0
) (
  input  logic                  sys_clk,
  input  logic                  sys_rst,

  input  logic [13:0]           csr_a_i,
  input  logic                  csr_we_i,
  input  hm_pkg::hm_word_t      csr_di_i,
  output hm_pkg::hm_word_t      csr_do_o,

  input  logic                  seq_busy_i,
  input  hm_pkg::hm_state_e     seq_state_i,
  input  logic                  done_i,
  input  logic                  tx_timeout_i,
  input  logic                  rx_timeout_i,
  input  logic                  wr_timeout_i,

  input  logic [7:0]            cfg_bus_number_i,
  input  logic [4:0]            cfg_device_number_i,
  input  logic [2:0]            cfg_function_number_i,

  output logic                  start_read_o,
  output logic                  start_write_o,
  output hm_pkg::hm_qword_t     host_addr_o,
  output hm_pkg::hm_word_t      host_data_o,
  output logic                  snoop_o,
  output hm_pkg::requester_id_t requester_id_o,
  output logic                  irq_o
);

  import hm_pkg::*;

  logic          csr_selected;
  csr_offset_t   csr_offset;
  logic          event_end;
  logic          event_tx_timeout;
  logic          event_rx_timeout;
  logic          event_wr_timeout;
  logic          irq_en;
  logic          override_id;
  requester_id_t oid;
  hm_word_t      stat_word;
  hm_word_t      ctrl_word;

  assign csr_selected = csr_a_i[13:10] == csr_block;
  assign csr_offset   = csr_a_i[9:0];

  assign requester_id_o = override_id ? oid :
    {cfg_bus_number_i, cfg_device_number_i, cfg_function_number_i};

  assign irq_o = irq_en & (event_end | event_tx_timeout | event_rx_timeout |
    event_wr_timeout);

  always_comb begin
    stat_word = '0;
    stat_word[STAT_END]        = event_end;
    stat_word[STAT_TX_TIMEOUT] = event_tx_timeout;
    stat_word[STAT_RX_TIMEOUT] = event_rx_timeout;
    stat_word[STAT_WR_TIMEOUT] = event_wr_timeout;
    ctrl_word = '0;
    ctrl_word[CTRL_IRQ_EN]      = irq_en;
    ctrl_word[CTRL_START_READ]  = start_read_o;
    ctrl_word[CTRL_START_WRITE] = start_write_o;
    ctrl_word[CTRL_SNOOP]       = snoop_o;
    ctrl_word[CTRL_OVERRIDE_ID] = override_id;
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      csr_do_o         <= '0;
      start_read_o     <= 1'b0;
      start_write_o    <= 1'b0;
      event_end        <= 1'b0;
      event_tx_timeout <= 1'b0;
      event_rx_timeout <= 1'b0;
      event_wr_timeout <= 1'b0;
      irq_en           <= 1'b0;
      override_id      <= 1'b0;
      snoop_o          <= 1'b1;
      host_addr_o      <= '0;
      host_data_o      <= '0;
      oid              <= '0;
    end else begin
      csr_do_o      <= '0;
      start_read_o  <= 1'b0;
      start_write_o <= 1'b0;
      if (csr_selected) begin
        case (csr_offset)
          CSR_STAT:      csr_do_o <= stat_word;
          CSR_CTRL:      csr_do_o <= ctrl_word;
          CSR_ADDR_LOW:  csr_do_o <= host_addr_o[31:0];
          CSR_ADDR_HIGH: csr_do_o <= host_addr_o[63:32];
          CSR_STATE:     csr_do_o <= {30'b0, seq_state_i};
          CSR_DATA:      csr_do_o <= host_data_o;
          CSR_ID:        csr_do_o <= {16'b0, oid};
          default:       csr_do_o <= '0;
        endcase
        if (csr_we_i) begin
          case (csr_offset)
            CSR_STAT: begin
              // Events stay put while a transfer runs
              if (!seq_busy_i) begin
                if (csr_di_i[STAT_END])        event_end        <= 1'b0;
                if (csr_di_i[STAT_TX_TIMEOUT]) event_tx_timeout <= 1'b0;
                if (csr_di_i[STAT_RX_TIMEOUT]) event_rx_timeout <= 1'b0;
                if (csr_di_i[STAT_WR_TIMEOUT]) event_wr_timeout <= 1'b0;
              end
            end
            CSR_CTRL: begin
              if (!seq_busy_i) begin
                irq_en <= csr_di_i[CTRL_IRQ_EN];
              end
              start_read_o  <= csr_di_i[CTRL_START_READ];
              start_write_o <= csr_di_i[CTRL_START_WRITE];
              snoop_o       <= csr_di_i[CTRL_SNOOP];
              override_id   <= csr_di_i[CTRL_OVERRIDE_ID];
            end
            CSR_ADDR_LOW:  host_addr_o[31:0]  <= csr_di_i;
            CSR_ADDR_HIGH: host_addr_o[63:32] <= csr_di_i;
            CSR_DATA:      host_data_o        <= csr_di_i;
            CSR_ID:        oid                <= csr_di_i[15:0];
            default:       ;
          endcase
        end
      end
      // A new event wins over a clear in the same cycle
      if (done_i)       event_end        <= 1'b1;
      if (tx_timeout_i) event_tx_timeout <= 1'b1;
      if (rx_timeout_i) event_rx_timeout <= 1'b1;
      if (wr_timeout_i) event_wr_timeout <= 1'b1;
    end
  end

endmodule

// ==== logic/hm_top.sv ====
module hm_top #(
  parameter logic [31:0] timeout_cycles = 32'd64,
  parameter logic [3:0]  csr_block      = 4'h0
) (
  input  logic                  sys_clk,
  input  logic                  sys_rst,

  input  logic [13:0]           csr_a_i,
  input  logic                  csr_we_i,
  input  hm_pkg::hm_word_t      csr_di_i,
  output hm_pkg::hm_word_t      csr_do_o,

  input  logic [31:0]           wb_adr_i,
  input  hm_pkg::hm_word_t      wb_dat_i,
  input  hm_pkg::byte_en_t      wb_sel_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  output hm_pkg::hm_word_t      wb_dat_o,
  output logic                  wb_ack_o,

  input  hm_pkg::hm_qword_t     hm_addr_i,
  output hm_pkg::hm_qword_t     hm_data_o,

  output logic                  tx_start_o,
  output logic                  wr_start_o,
  input  logic                  tx_end_i,
  input  logic                  rx_done_i,
  input  logic                  wr_end_i,
  output hm_pkg::hm_qword_t     engine_addr_o,
  output hm_pkg::hm_word_t      engine_data_o,
  output logic                  snoop_o,
  output hm_pkg::requester_id_t requester_id_o,

  input  logic [7:0]            cfg_bus_number_i,
  input  logic [4:0]            cfg_device_number_i,
  input  logic [2:0]            cfg_function_number_i,

  output logic                  irq_o
);

  import hm_pkg::*;

  logic       start_read;
  logic       start_write;
  hm_qword_t  host_addr;
  logic       seq_busy;
  hm_state_e  seq_state;
  logic       seq_done;
  logic       tx_timeout;
  logic       rx_timeout;
  logic       wr_timeout;
  buf_index_t bank_index;
  hm_word_t   bank_wdata;
  byte_en_t   bank_we_lo;
  byte_en_t   bank_we_hi;
  hm_word_t   bank_rd_lo;
  hm_word_t   bank_rd_hi;

  hm_csr_regs #(
    .csr_block(csr_block)
  ) csr_regs (
    .sys_clk              (sys_clk),
    .sys_rst              (sys_rst),
    .csr_a_i              (csr_a_i),
    .csr_we_i             (csr_we_i),
    .csr_di_i             (csr_di_i),
    .csr_do_o             (csr_do_o),
    .seq_busy_i           (seq_busy),
    .seq_state_i          (seq_state),
    .done_i               (seq_done),
    .tx_timeout_i         (tx_timeout),
    .rx_timeout_i         (rx_timeout),
    .wr_timeout_i         (wr_timeout),
    .cfg_bus_number_i     (cfg_bus_number_i),
    .cfg_device_number_i  (cfg_device_number_i),
    .cfg_function_number_i(cfg_function_number_i),
    .start_read_o         (start_read),
    .start_write_o        (start_write),
    .host_addr_o          (host_addr),
    .host_data_o          (engine_data_o),
    .snoop_o              (snoop_o),
    .requester_id_o       (requester_id_o),
    .irq_o                (irq_o)
  );

  hm_sequencer #(
    .timeout_cycles(timeout_cycles)
  ) sequencer (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .start_read_i (start_read),
    .start_write_i(start_write),
    .host_addr_i  (host_addr),
    .tx_end_i     (tx_end_i),
    .rx_done_i    (rx_done_i),
    .wr_end_i     (wr_end_i),
    .seq_busy_o   (seq_busy),
    .seq_state_o  (seq_state),
    .done_o       (seq_done),
    .tx_timeout_o (tx_timeout),
    .rx_timeout_o (rx_timeout),
    .wr_timeout_o (wr_timeout),
    .tx_start_o   (tx_start_o),
    .wr_start_o   (wr_start_o),
    .engine_addr_o(engine_addr_o)
  );

  hm_buffer_window buffer_window (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .hm_addr_i   (hm_addr_i),
    .hm_data_o   (hm_data_o),
    .bank_rd_lo_i(bank_rd_lo),
    .bank_rd_hi_i(bank_rd_hi),
    .bank_index_o(bank_index),
    .bank_wdata_o(bank_wdata),
    .bank_we_lo_o(bank_we_lo),
    .bank_we_hi_o(bank_we_hi)
  );

  // Low word of each 64-bit entry
  hm_buffer_bank bank_lo (
    .sys_clk(sys_clk),
    .index_i(bank_index),
    .wdata_i(bank_wdata),
    .we_i   (bank_we_lo),
    .rdata_o(bank_rd_lo)
  );

  hm_buffer_bank bank_hi (
    .sys_clk(sys_clk),
    .index_i(bank_index),
    .wdata_i(bank_wdata),
    .we_i   (bank_we_hi),
    .rdata_o(bank_rd_hi)
  );

endmodule

// ==== sequencer/hm_sequencer.sv ====
module hm_sequencer #(
  parameter logic [31:0] timeout_cycles = 32'd64
) (
  input  logic              sys_clk,
  input  logic              sys_rst,

  input  logic              start_read_i,
  input  logic              start_write_i,
  input  hm_pkg::hm_qword_t host_addr_i,

  input  logic              tx_end_i,
  input  logic              rx_done_i,
  input  logic              wr_end_i,

  output logic              seq_busy_o,
  output hm_pkg::hm_state_e seq_state_o,
  output logic              done_o,
  output logic              tx_timeout_o,
  output logic              rx_timeout_o,
  output logic              wr_timeout_o,

  output logic              tx_start_o,
  output logic              wr_start_o,
  output hm_pkg::hm_qword_t engine_addr_o
);

  import hm_pkg::*;

  hm_state_e   state;
  logic [31:0] watchdog;
  logic        watchdog_expired;

  assign seq_state_o      = state;
  assign seq_busy_o       = state != HM_IDLE;
  assign watchdog_expired = watchdog == timeout_cycles;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state         <= HM_IDLE;
      watchdog      <= '0;
      done_o        <= 1'b0;
      tx_timeout_o  <= 1'b0;
      rx_timeout_o  <= 1'b0;
      wr_timeout_o  <= 1'b0;
      tx_start_o    <= 1'b0;
      wr_start_o    <= 1'b0;
      engine_addr_o <= '0;
    end else begin
      done_o       <= 1'b0;
      tx_timeout_o <= 1'b0;
      rx_timeout_o <= 1'b0;
      wr_timeout_o <= 1'b0;
      tx_start_o   <= 1'b0;
      wr_start_o   <= 1'b0;

      case (state)
        HM_IDLE: begin
          // Read has priority over write
          if (start_read_i) begin
            state         <= HM_SEND;
            tx_start_o    <= 1'b1;
            engine_addr_o <= {host_addr_i[63:PAGE_BITS], {PAGE_BITS{1'b0}}};
          end else if (start_write_i) begin
            state         <= HM_WRITE;
            wr_start_o    <= 1'b1;
            engine_addr_o <= host_addr_i;
          end
        end
        HM_SEND: begin
          if (tx_end_i) state <= HM_RECV;
        end
        HM_RECV: begin
          if (rx_done_i) begin
            state  <= HM_IDLE;
            done_o <= 1'b1;
          end
        end
        HM_WRITE: begin
          if (wr_end_i) begin
            state  <= HM_IDLE;
            done_o <= 1'b1;
          end
        end
      endcase

      // Watchdog overrides whatever the engine did this cycle
      if (state == HM_IDLE) begin
        watchdog <= '0;
      end else if (watchdog_expired) begin
        watchdog <= '0;
        state    <= HM_IDLE;
        case (state)
          HM_SEND:  tx_timeout_o <= 1'b1;
          HM_RECV:  rx_timeout_o <= 1'b1;
          HM_WRITE: begin
            wr_timeout_o <= 1'b1;
            done_o       <= 1'b1;
          end
          default:  ;
        endcase
      end else begin
        watchdog <= watchdog + 32'd1;
      end
    end
  end

endmodule
